//--- source/rvCorePkg.sv
package rvCorePkg;

    typedef logic [63:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [1:0]  aluOp_t;
    typedef logic        wbSel_t;

    localparam aluOp_t ALU_ADD    = 2'd0;
    localparam aluOp_t ALU_PASS_B = 2'd1; // lui

    localparam wbSel_t WB_ALU  = 1'b0;
    localparam wbSel_t WB_LINK = 1'b1; // pc+4 for jal

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam xlen_t RESET_PC = 64'h0;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetchPacket_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        regIdx_t    rd;
        logic       writeRd;
        aluOp_t     aluOp;
        xlen_t      opA;
        xlen_t      opB;
        wbSel_t     wbSel;
        logic       isStore;
        logic [7:0] storeMask;
        xlen_t      storeData;
        logic       isHalt;
    } decodedInst_t;

    typedef struct packed {
        xlen_t      addr;
        xlen_t      data;
        logic [7:0] mask; // byte lanes from offset 0
    } storeReq_t;

endpackage

//--- source/instFetch.sv
module instFetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    redirect,
    input  rvCorePkg::xlen_t        redirectPc,
    input  logic                    haltSeen,
    output rvCorePkg::xlen_t        instAddr,
    input  rvCorePkg::inst_t        inst,
    output rvCorePkg::fetchPacket_t fetchOut
);

    rvCorePkg::xlen_t pc;
    logic stopped; // sticky once ebreak decoded

    assign instAddr = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc             <= rvCorePkg::RESET_PC;
            stopped        <= 1'b0;
            fetchOut.valid <= 1'b0;
        end
        else if (!stall)
        begin
            if (redirect)
            begin
                pc             <= redirectPc;
                fetchOut.valid <= 1'b0; // bubble for the wrong-path slot
            end
            else if (haltSeen || stopped)
            begin
                stopped        <= 1'b1;
                fetchOut.valid <= 1'b0;
            end
            else
            begin
                pc             <= pc + 64'd4;
                fetchOut.valid <= 1'b1;
                fetchOut.pc    <= pc;
                fetchOut.inst  <= inst;
            end
        end
    end

endmodule

//--- source/instDecoder.sv
module instDecoder (
    input  rvCorePkg::fetchPacket_t fetchIn,
    output rvCorePkg::regIdx_t      rs1Idx,
    output rvCorePkg::regIdx_t      rs2Idx,
    input  rvCorePkg::xlen_t        rs1Val,
    input  rvCorePkg::xlen_t        rs2Val,
    input  rvCorePkg::regIdx_t      fwdRd,
    input  logic                    fwdValid,
    input  rvCorePkg::xlen_t        fwdVal,
    output rvCorePkg::decodedInst_t decOut,
    output logic                    redirect,
    output rvCorePkg::xlen_t        redirectPc,
    output logic                    haltSeen
);

    logic [6:0] opCode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    rvCorePkg::regIdx_t rd;
    rvCorePkg::xlen_t immI;
    rvCorePkg::xlen_t immS;
    rvCorePkg::xlen_t immU;
    rvCorePkg::xlen_t immJ;
    rvCorePkg::xlen_t rs1Fwd;
    rvCorePkg::xlen_t rs2Fwd;
    logic [7:0] mask;

    assign opCode = fetchIn.inst[6:0];
    assign funct7 = fetchIn.inst[31:25];
    assign funct3 = fetchIn.inst[14:12];
    assign rd     = fetchIn.inst[11:7];
    assign rs1Idx = fetchIn.inst[19:15];
    assign rs2Idx = fetchIn.inst[24:20];

    assign immI = {{52{fetchIn.inst[31]}}, fetchIn.inst[31:20]};
    assign immS = {{52{fetchIn.inst[31]}}, fetchIn.inst[31:25], fetchIn.inst[11:7]};
    assign immU = {{32{fetchIn.inst[31]}}, fetchIn.inst[31:12], 12'b0};
    assign immJ = {{44{fetchIn.inst[31]}}, fetchIn.inst[19:12], fetchIn.inst[20],
                   fetchIn.inst[30:21], 1'b0};

    // exec writes back this cycle, regfile only sees it next cycle
    assign rs1Fwd = (fwdValid && fwdRd == rs1Idx) ? fwdVal : rs1Val;
    assign rs2Fwd = (fwdValid && fwdRd == rs2Idx) ? fwdVal : rs2Val;

    always_comb
    begin
        case (funct3)
            3'b000:  mask = 8'h01; // sb
            3'b001:  mask = 8'h03; // sh
            3'b010:  mask = 8'h0f; // sw
            3'b011:  mask = 8'hff; // sd
            default: mask = 8'h00;
        endcase
    end

    always_comb
    begin
        decOut           = '0;
        decOut.valid     = fetchIn.valid;
        decOut.pc        = fetchIn.pc;
        decOut.rd        = rd;
        decOut.aluOp     = rvCorePkg::ALU_ADD;
        decOut.wbSel     = rvCorePkg::WB_ALU;
        decOut.opA       = rs1Fwd;
        decOut.opB       = immI;
        decOut.storeData = rs2Fwd;
        redirect         = 1'b0;
        redirectPc       = fetchIn.pc + immJ;
        haltSeen         = 1'b0;
        if (fetchIn.valid)
        begin
            case (opCode)
                rvCorePkg::OP_REG:
                begin
                    decOut.opB     = rs2Fwd;
                    decOut.writeRd = (funct3 == 3'b0) && (funct7 == 7'b0) && (rd != '0);
                end
                rvCorePkg::OP_IMM:
                    decOut.writeRd = (funct3 == 3'b0) && (rd != '0); // addi only
                rvCorePkg::OP_AUIPC:
                begin
                    decOut.opA     = fetchIn.pc;
                    decOut.opB     = immU;
                    decOut.writeRd = (rd != '0);
                end
                rvCorePkg::OP_LUI:
                begin
                    decOut.aluOp   = rvCorePkg::ALU_PASS_B;
                    decOut.opB     = immU;
                    decOut.writeRd = (rd != '0);
                end
                rvCorePkg::OP_JAL:
                begin
                    decOut.wbSel   = rvCorePkg::WB_LINK;
                    decOut.writeRd = (rd != '0);
                    redirect       = 1'b1;
                end
                rvCorePkg::OP_STORE:
                begin
                    decOut.opB       = immS; // address is rs1 + imm
                    decOut.storeMask = mask;
                    decOut.isStore   = (mask != 8'h00);
                end
                rvCorePkg::OP_SYSTEM:
                begin
                    decOut.isHalt = (funct3 == 3'b0) && (fetchIn.inst[31:20] == 12'd1);
                    haltSeen      = decOut.isHalt;
                end
                default: ; // retires as a no-op
            endcase
        end
    end

endmodule

//--- source/regFile.sv
module regFile (
    input  logic               clk,
    input  logic               rst,
    input  rvCorePkg::regIdx_t rs1Idx,
    input  rvCorePkg::regIdx_t rs2Idx,
    output rvCorePkg::xlen_t   rs1Val,
    output rvCorePkg::xlen_t   rs2Val,
    input  logic               wrEn,
    input  rvCorePkg::regIdx_t wrIdx,
    input  rvCorePkg::xlen_t   wrData
);

    rvCorePkg::xlen_t regs [32];

    assign rs1Val = regs[rs1Idx];
    assign rs2Val = regs[rs2Idx];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wrEn && wrIdx != '0) // x0 stays zero
        begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

//--- source/execStage.sv
module execStage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  rvCorePkg::decodedInst_t decIn,
    output logic                    wrEn,
    output rvCorePkg::regIdx_t      wrIdx,
    output rvCorePkg::xlen_t        wrData,
    output logic                    storeValid,
    output rvCorePkg::storeReq_t    storeOut,
    input  logic                    storeBusy,
    output logic                    stallOut,
    output logic                    halted
);

    rvCorePkg::decodedInst_t decReg;
    rvCorePkg::xlen_t aluResult;
    logic haltPend;
    logic haltReq;

    assign aluResult = (decReg.aluOp == rvCorePkg::ALU_PASS_B) ? decReg.opB
                                                               : decReg.opA + decReg.opB;

    assign stallOut = decReg.valid && decReg.isStore && storeBusy;

    assign wrEn   = decReg.valid && decReg.writeRd && !stallOut;
    assign wrIdx  = decReg.rd;
    assign wrData = (decReg.wbSel == rvCorePkg::WB_LINK) ? decReg.pc + 64'd4 : aluResult;

    assign storeValid     = decReg.valid && decReg.isStore && !storeBusy;
    assign storeOut.addr  = aluResult;
    assign storeOut.data  = decReg.storeData;
    assign storeOut.mask  = decReg.storeMask;

    // ebreak leaves exec after one cycle, so remember it until stores drain
    assign haltReq = haltPend || (decReg.valid && decReg.isHalt);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            decReg.valid <= 1'b0;
            haltPend     <= 1'b0;
            halted       <= 1'b0;
        end
        else
        begin
            if (!stall)
                decReg <= decIn;
            if (haltReq)
                haltPend <= 1'b1;
            if (haltReq && !storeBusy)
                halted <= 1'b1;
        end
    end

endmodule

//--- source/storeUnit.sv
module storeUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 storeValid,
    input  rvCorePkg::storeReq_t storeIn,
    output logic                 storeBusy,
    output logic                 awvalid,
    input  logic                 awready,
    output rvCorePkg::xlen_t     awaddr,
    output logic                 wvalid,
    input  logic                 wready,
    output rvCorePkg::xlen_t     wdata,
    output logic [7:0]           wstrb,
    input  logic                 bvalid,
    output logic                 bready,
    input  logic [1:0]           bresp
);

    typedef enum logic [1:0] {IDLE, ADDR_DATA, RESP} state_t;

    state_t state;
    logic awNext;
    logic wNext;

    assign storeBusy = (state != IDLE);

    // each channel drops its valid on its own handshake
    assign awNext = awvalid && !awready;
    assign wNext  = wvalid && !wready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (storeValid)
                    begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= ADDR_DATA;
                    end
                ADDR_DATA:
                begin
                    awvalid <= awNext;
                    wvalid  <= wNext;
                    if (!awNext && !wNext)
                    begin
                        bready <= 1'b1;
                        state  <= RESP;
                    end
                end
                RESP:
                    if (bvalid) // response code not checked
                    begin
                        bready <= 1'b0;
                        state  <= IDLE;
                    end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == IDLE && storeValid)
        begin
            awaddr <= storeIn.addr;
            wdata  <= storeIn.data << {storeIn.addr[2:0], 3'b000}; // 8 bits per lane
            wstrb  <= storeIn.mask << storeIn.addr[2:0];
        end
    end

endmodule

//--- source/rvCoreTop.sv
module rvCoreTop (
    input  logic             clk,
    input  logic             rst,
    output rvCorePkg::xlen_t instAddr,
    input  rvCorePkg::inst_t inst,
    output logic             awvalid,
    input  logic             awready,
    output rvCorePkg::xlen_t awaddr,
    output logic             wvalid,
    input  logic             wready,
    output rvCorePkg::xlen_t wdata,
    output logic [7:0]       wstrb,
    input  logic             bvalid,
    output logic             bready,
    input  logic [1:0]       bresp,
    output logic             halted
);

    rvCorePkg::fetchPacket_t fetchPkt;
    rvCorePkg::decodedInst_t decPkt;
    rvCorePkg::storeReq_t    storeReq;
    rvCorePkg::regIdx_t      rs1Idx;
    rvCorePkg::regIdx_t      rs2Idx;
    rvCorePkg::regIdx_t      wrIdx;
    rvCorePkg::xlen_t        rs1Val;
    rvCorePkg::xlen_t        rs2Val;
    rvCorePkg::xlen_t        wrData;
    rvCorePkg::xlen_t        redirectPc;
    logic redirect;
    logic haltSeen;
    logic wrEn;
    logic storeValid;
    logic storeBusy;
    logic stall;

    instFetch fetch (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .redirectPc(redirectPc), .haltSeen(haltSeen), .instAddr(instAddr),
        .inst(inst), .fetchOut(fetchPkt)
    );

    instDecoder decoder (
        .fetchIn(fetchPkt), .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Val(rs1Val),
        .rs2Val(rs2Val), .fwdRd(wrIdx), .fwdValid(wrEn), .fwdVal(wrData),
        .decOut(decPkt), .redirect(redirect), .redirectPc(redirectPc), .haltSeen(haltSeen)
    );

    regFile regs (
        .clk(clk), .rst(rst), .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Val(rs1Val),
        .rs2Val(rs2Val), .wrEn(wrEn), .wrIdx(wrIdx), .wrData(wrData)
    );

    execStage exec (
        .clk(clk), .rst(rst), .stall(stall), .decIn(decPkt), .wrEn(wrEn),
        .wrIdx(wrIdx), .wrData(wrData), .storeValid(storeValid), .storeOut(storeReq),
        .storeBusy(storeBusy), .stallOut(stall), .halted(halted)
    );

    storeUnit store (
        .clk(clk), .rst(rst), .storeValid(storeValid), .storeIn(storeReq),
        .storeBusy(storeBusy), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp)
    );

endmodule

//--- tb/storeBus_chk.sv
module storeBus_chk (
    input logic             clk,
    input logic             rst,
    input logic             awvalid,
    input logic             awready,
    input rvCorePkg::xlen_t awaddr,
    input logic             wvalid,
    input logic             wready,
    input rvCorePkg::xlen_t wdata,
    input logic [7:0]       wstrb,
    input logic             halted
);

    awHold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped or awaddr moved before awready");

    wHold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid dropped or write payload moved before wready");

    quietAfterHalt: assert property (@(posedge clk) disable iff (rst)
        halted |-> !awvalid)
        else $error("write address issued after halt");

endmodule

bind rvCoreTop storeBus_chk storeChk (
    .clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb), .halted(halted)
);

//--- tb/rvCoreTb.sv
module rvCoreTb;

    localparam int RAND_LEN     = 64;
    localparam int SWEEP_LEN    = 14;
    localparam int PROG_LEN     = RAND_LEN + SWEEP_LEN + 33; // random, lane sweep, dump, ebreak
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        rst;
    logic [63:0] instAddr;
    logic [31:0] inst;
    logic        awvalid;
    logic        awready = 1'b0;
    logic [63:0] awaddr;
    logic        wvalid;
    logic        wready = 1'b0;
    logic [63:0] wdata;
    logic [7:0]  wstrb;
    logic        bvalid = 1'b0;
    logic        bready;
    logic [1:0]  bresp = 2'b00;
    logic        halted;

    logic [31:0] imem [256];
    logic [15:0] lfsr = 16'd71;
    logic [63:0] expAddr [$];
    logic [7:0]  expStrb [$];
    logic [63:0] expData [$];

    logic        awSeen = 1'b0;
    logic        wSeen = 1'b0;
    logic        respPending = 1'b0;
    int          respDelay;
    logic [63:0] beatAddr;
    logic [63:0] beatData;
    logic [7:0]  beatStrb;

    rvCoreTop DUT (
        .clk(clk), .rst(rst), .instAddr(instAddr), .inst(inst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp), .halted(halted)
    );

    assign inst = imem[instAddr[9:2]]; // combinational fetch

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r    = {r[30:0], lfsr[15]};
            lfsr = lfsrStep(lfsr);
        end
        return r;
    endfunction

    function automatic logic [31:0] encAdd(input logic [4:0] rd, rs1, rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encAddi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encUpper(input logic [6:0] op, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, op}; // lui and auipc
    endfunction

    function automatic logic [31:0] encJal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encStore(input logic [2:0] f3, input logic [4:0] rs2,
                                             input logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base is x0
    endfunction

    function automatic logic [63:0] laneBits(input logic [7:0] strb);
        logic [63:0] m;
        for (int b = 0; b < 8; b++)
            m[8*b +: 8] = {8{strb[b]}};
        return m;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic buildProgram();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  lastRd;
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [11:0] off;
        int n;
        lastRd = 5'd1;
        n = 0;
        for (int i = 0; i < 256; i++)
            imem[i] = {i[24:0], 7'b0001011}; // custom-0 filler that is never reached
        for (int k = 0; k < RAND_LEN; k++)
        begin
            kind = 4'(randBits(4));
            rd   = 5'(randBits(4));
            rs2  = 5'(randBits(4));
            if (randBits(1) == 32'd1)
                rs1 = lastRd; // back-to-back dependency
            else
                rs1 = 5'(randBits(4));
            case (kind)
                4'd0, 4'd1, 4'd2: imem[k] = encAdd(rd, rs1, rs2);
                4'd5: imem[k] = encUpper(7'b0110111, rd, 20'(randBits(20)));
                4'd6: imem[k] = encUpper(7'b0010111, rd, 20'(randBits(20)));
                4'd7, 4'd8:
                begin
                    if (k + 3 <= RAND_LEN)
                        imem[k] = encJal(rd, (randBits(1) == 32'd1) ? 21'd8 : 21'd12);
                    else
                        imem[k] = encAdd(rd, rs1, rs2);
                end
                4'd9, 4'd10, 4'd11, 4'd12:
                begin
                    f3      = 3'(randBits(2));
                    off     = 12'(randBits(10)) & ~((12'd1 << f3) - 12'd1); // natural alignment
                    imem[k] = encStore(f3, rs2, off);
                end
                4'd13: imem[k] = {25'(randBits(25)), 7'b0000011}; // unsupported load
                default: imem[k] = encAddi(rd, rs1, 12'(randBits(12)));
            endcase
            lastRd = rd;
        end
        // sb, sh, sw at every aligned offset
        for (int f = 0; f < 3; f++)
        begin
            for (int o = 0; o < 8; o += (1 << f))
            begin
                imem[RAND_LEN + n] = encStore(3'(f), 5'(1 + n % 15), 12'(12'h200 + o));
                n++;
            end
        end
        for (int r = 0; r < 32; r++)
            imem[RAND_LEN + SWEEP_LEN + r] = encStore(3'd3, 5'(r), 12'(12'h400 + 8 * r));
        imem[PROG_LEN - 1] = 32'h00100073; // ebreak
    endtask

    task automatic runModel();
        logic [63:0] xreg [32];
        logic [63:0] pc;
        logic [63:0] nextPc;
        logic [63:0] addr;
        logic [63:0] lane;
        logic [31:0] w;
        logic [7:0]  strb;
        logic        done;
        int steps;
        int size;
        pc    = 64'd0;
        done  = 1'b0;
        steps = 0;
        for (int r = 0; r < 32; r++)
            xreg[r] = 64'd0;
        while (!done && steps < PROG_LEN)
        begin
            w      = imem[pc[9:2]];
            nextPc = pc + 64'd4;
            case (w[6:0])
                7'b0110011:
                    if (w[14:12] == 3'b000 && w[31:25] == 7'b0)
                        xreg[w[11:7]] = xreg[w[19:15]] + xreg[w[24:20]];
                7'b0010011:
                    if (w[14:12] == 3'b000)
                        xreg[w[11:7]] = xreg[w[19:15]] + {{52{w[31]}}, w[31:20]};
                7'b0110111: xreg[w[11:7]] = {{32{w[31]}}, w[31:12], 12'b0};
                7'b0010111: xreg[w[11:7]] = pc + {{32{w[31]}}, w[31:12], 12'b0};
                7'b1101111:
                begin
                    xreg[w[11:7]] = pc + 64'd4;
                    nextPc = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                7'b0100011:
                    if (w[14] == 1'b0)
                    begin
                        addr = xreg[w[19:15]] + {{52{w[31]}}, w[31:25], w[11:7]};
                        size = 1 << w[13:12]; // bytes in the store
                        strb = '0;
                        lane = '0;
                        // byte k of rs2 lands in lane offset+k
                        for (int k = 0; k < size; k++)
                        begin
                            strb[addr[2:0] + k] = 1'b1;
                            lane[8 * (addr[2:0] + k) +: 8] = xreg[w[24:20]][8 * k +: 8];
                        end
                        expAddr.push_back(addr);
                        expStrb.push_back(strb);
                        expData.push_back(lane);
                    end
                7'b1110011: done = (w == 32'h00100073);
                default: ; // no architectural effect
            endcase
            xreg[0] = 64'd0;
            pc      = nextPc;
            steps++;
        end
        if (!done)
            abortRun("the reference model never reached the ebreak");
    endtask

    task automatic matchStore();
        logic [63:0] lanes;
        if (expAddr.size() == 0)
            abortRun("a store arrived on the bus that the program never issued");
        else
        begin
            lanes = laneBits(expStrb[0]);
            compareValue("awaddr", beatAddr, expAddr[0]);
            compareValue("wstrb", 64'(beatStrb), 64'(expStrb[0]));
            compareValue("wdata", beatData & lanes, expData[0] & lanes);
            void'(expAddr.pop_front());
            void'(expStrb.pop_front());
            void'(expData.pop_front());
        end
    endtask

    task automatic serveBus();
        if (rst)
        begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            bvalid      <= 1'b0;
            awSeen      = 1'b0;
            wSeen       = 1'b0;
            respPending = 1'b0;
        end
        else
        begin
            if (awvalid && awready)
            begin
                if (awSeen)
                    abortRun("a second write address arrived before its write data");
                else
                begin
                    awSeen   = 1'b1;
                    beatAddr = awaddr;
                end
            end
            if (wvalid && wready)
            begin
                if (wSeen)
                    abortRun("a second write data beat arrived before its address");
                else
                begin
                    wSeen    = 1'b1;
                    beatData = wdata;
                    beatStrb = wstrb;
                end
            end
            if (awSeen && wSeen)
            begin
                matchStore();
                awSeen      = 1'b0;
                wSeen       = 1'b0;
                respPending = 1'b1;
                respDelay   = randBits(2);
            end
            if (bvalid && bready)
                bvalid <= 1'b0;
            else if (respPending && !bvalid)
            begin
                if (respDelay == 0)
                begin
                    bvalid      <= 1'b1;
                    respPending = 1'b0;
                end
                else
                    respDelay--;
            end
            awready <= (randBits(2) != 32'd0);
            wready  <= (randBits(2) != 32'd0);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        buildProgram();
        runModel();
        forever
        begin
            @(posedge clk);
            serveBus();
        end
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        compareValue("instAddr", instAddr, 64'd0);
        compareValue("awvalid", 64'(awvalid), 64'd0);
        compareValue("wvalid", 64'(wvalid), 64'd0);
        compareValue("bready", 64'(bready), 64'd0);
        compareValue("halted", 64'(halted), 64'd0);
        rst <= 1'b0;
        while (halted !== 1'b1)
            @(posedge clk);
        if (expAddr.size() != 0 || awSeen || wSeen)
            abortRun("the core halted while expected stores were still missing");
        else
        begin
            repeat (20)
            begin
                @(posedge clk);
                compareValue("halted", 64'(halted), 64'd1); // sticky
                compareValue("awvalid", 64'(awvalid), 64'd0);
                compareValue("wvalid", 64'(wvalid), 64'd0);
            end
            $display("Test completed successfully");
            $finish;
        end
    end

    initial
    begin
        repeat (RESET_CYCLES + PROG_LEN * 40) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", PROG_LEN * 40);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- build.f
source/rvCorePkg.sv
source/instFetch.sv
source/instDecoder.sv
source/regFile.sv
source/execStage.sv
source/storeUnit.sv
source/rvCoreTop.sv
tb/storeBus_chk.sv
tb/rvCoreTb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module rvCoreTb -f build.f
	-./obj_dir/VrvCoreTb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
